/* hdl/vpu_sp_cfg.svh */
`ifndef VPU_SP_CFG_SVH
`define VPU_SP_CFG_SVH

// sprite table
`define SP_COUNT      8
`define SP_IDX_W      3
`define PARAM_WORDS   2
`define PARAM_ADDR_W  4

// visible line
`define SCREEN_W      256

// tile geometry, one tile is HW_TILE_W square
`define HW_TILE_W     8
`define TILE_IDX_W    8
`define TILE_BANK_W   2

// memory address widths
`define TILE_ADDR_W   16
`define PAL_ADDR_W    10
`define LB_ADDR_W     8

`endif

/* hdl/vpu_sp_pkg.sv */
`include "vpu_sp_cfg.svh"

package vpu_sp_pkg;

  // sprite side in pixels, 8 to 64
  typedef logic [6:0] sp_size_t;

  typedef struct packed {
    logic                    enable;
    logic [1:0]              tilesize;
    logic [8:0]              x;
    logic [7:0]              y;
    logic [`TILE_BANK_W-1:0] tile_bank;
    logic [`TILE_IDX_W-1:0]  tile_idx;
    logic                    pal_mode;
    logic [1:0]              pal_bank;
    logic [3:0]              pal_no;
  } sp_attr_t;

  // one pixel between the pipeline stages
  typedef struct packed {
    logic       valid;
    logic       last;
    logic [8:0] x;
    logic       pal_mode;
    logic [1:0] pal_bank;
    logic [3:0] pal_no;
    logic [7:0] idx;
  } sp_pix_t;

  typedef struct packed {
    logic [7:0] a;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } sp_argb_t;

  // tilesize code to side length
  function automatic sp_size_t sp_size(input logic [1:0] tilesize);
    return sp_size_t'(`HW_TILE_W << tilesize);
  endfunction

endpackage

/* hdl/vpu_mem_pkg.sv */
`include "vpu_sp_cfg.svh"

package vpu_mem_pkg;

  typedef struct packed {
    logic                     en;
    logic [`PARAM_ADDR_W-1:0] addr;
  } param_req_t;

  typedef struct packed {
    logic                    en;
    logic [`TILE_ADDR_W-1:0] addr;
  } tile_req_t;

  typedef struct packed {
    logic                   en;
    logic [`PAL_ADDR_W-1:0] addr;
  } pal_req_t;

  // separate read and write address, the merge writes pixel n
  // in the cycle where pixel n+1 is read
  typedef struct packed {
    logic                  rd_en;
    logic [`LB_ADDR_W-1:0] rd_addr;
    logic                  wr_en;
    logic [`LB_ADDR_W-1:0] wr_addr;
    vpu_sp_pkg::sp_argb_t  wdata;
  } lb_req_t;

endpackage

/* hdl/vpu_sp_sequencer.sv */
`timescale 1ns/100ps
`include "vpu_sp_cfg.svh"

module vpu_sp_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 line_start,
  input  logic [7:0]           line_y,
  output logic                 busy,
  output logic                 line_done,
  output logic                 load_start,
  output logic [`SP_IDX_W-1:0] sp_idx,
  input  logic                 load_done,
  input  logic                 visible,
  output logic                 walk_start,
  input  logic                 pass_done,
  output logic [7:0]           cur_y
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_WALK,
    ST_FINISH
  } state_t;

  state_t state;
  logic   last_sp;

  assign last_sp = (sp_idx == `SP_IDX_W'(`SP_COUNT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      busy       <= 1'b0;
      line_done  <= 1'b0;
      load_start <= 1'b0;
      walk_start <= 1'b0;
      sp_idx     <= '0;
    end else begin
      load_start <= 1'b0;
      walk_start <= 1'b0;
      line_done  <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (line_start) begin
            busy       <= 1'b1;
            sp_idx     <= '0;
            load_start <= 1'b1;
            state      <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          if (load_done) begin
            if (visible) begin
              walk_start <= 1'b1;
              state      <= ST_WALK;
            end else if (last_sp) begin
              state <= ST_FINISH;
            end else begin
              // skip straight to the next sprite
              sp_idx     <= sp_idx + 1'b1;
              load_start <= 1'b1;
            end
          end
        end
        ST_WALK: begin
          // pipeline drained once pass_done arrives
          if (pass_done) begin
            if (last_sp) begin
              state <= ST_FINISH;
            end else begin
              sp_idx     <= sp_idx + 1'b1;
              load_start <= 1'b1;
              state      <= ST_LOAD;
            end
          end
        end
        ST_FINISH: begin
          busy      <= 1'b0;
          line_done <= 1'b1;
          state     <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && line_start) begin
      cur_y <= line_y;
    end
  end

endmodule

/* hdl/vpu_sp_param_load.sv */
`timescale 1ns/100ps
`include "vpu_sp_cfg.svh"

module vpu_sp_param_load (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load_start,
  input  logic [`SP_IDX_W-1:0]    sp_idx,
  input  logic [7:0]              cur_y,
  output vpu_mem_pkg::param_req_t param_req,
  input  logic [31:0]             param_rdata,
  output logic                    load_done,
  output logic                    visible,
  output vpu_sp_pkg::sp_attr_t    attr
);
  import vpu_sp_pkg::*;

  // word0_ret: word 0 on param_rdata, word 1 requested
  logic       word0_ret;
  logic       word1_ret;
  logic [8:0] y_end;

  assign param_req.en   = load_start | word0_ret;
  assign param_req.addr = `PARAM_ADDR_W'(sp_idx * `PARAM_WORDS)
                        + `PARAM_ADDR_W'(word0_ret);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word0_ret <= 1'b0;
      word1_ret <= 1'b0;
      load_done <= 1'b0;
    end else begin
      word0_ret <= load_start;
      word1_ret <= word0_ret;
      load_done <= word1_ret;
    end
  end

  always_ff @(posedge clk) begin
    if (word0_ret) begin
      attr.enable   <= param_rdata[31];
      attr.tilesize <= param_rdata[25:24];
      attr.x        <= param_rdata[16:8];
      attr.y        <= param_rdata[7:0];
    end
    if (word1_ret) begin
      attr.tile_bank <= param_rdata[29:28];
      attr.tile_idx  <= param_rdata[23:16];
      attr.pal_mode  <= param_rdata[6];
      attr.pal_bank  <= param_rdata[5:4];
      attr.pal_no    <= param_rdata[3:0];
    end
  end

  // 9 bits so a sprite near the bottom does not wrap
  assign y_end = {1'b0, attr.y} + 9'(sp_size(attr.tilesize));

  assign visible = attr.enable && (attr.y <= cur_y) && ({1'b0, cur_y} < y_end);

endmodule

/* hdl/vpu_sp_tile_fetch.sv */
`timescale 1ns/100ps
`include "vpu_sp_cfg.svh"

module vpu_sp_tile_fetch (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   walk_start,
  input  vpu_sp_pkg::sp_attr_t   attr,
  input  logic [7:0]             cur_y,
  output vpu_mem_pkg::tile_req_t tile_req,
  output vpu_sp_pkg::sp_pix_t    pix
);
  import vpu_sp_pkg::*;

  localparam int LO_W = `TILE_ADDR_W - `TILE_BANK_W;

  logic                   active;
  sp_size_t               objx;
  sp_size_t               size;
  logic [7:0]             objy;
  logic                   last_pix;
  logic [`TILE_IDX_W-1:0] tile_num;
  logic [LO_W-1:0]        addr_lo;
  logic [9:0]             scr_x;

  assign size     = sp_size(attr.tilesize);
  assign objy     = cur_y - attr.y;
  assign last_pix = (objx == size - 1'b1);

  // tiles of a sprite are stored row by row, size/8 tiles per row
  always_comb begin
    tile_num = attr.tile_idx + `TILE_IDX_W'(objx / `HW_TILE_W)
             + `TILE_IDX_W'((objy / `HW_TILE_W) * (size / `HW_TILE_W));
    addr_lo  = LO_W'(tile_num * (`HW_TILE_W * `HW_TILE_W)
             + (objy % `HW_TILE_W) * `HW_TILE_W + objx % `HW_TILE_W);
  end

  assign tile_req.en   = active;
  assign tile_req.addr = {attr.tile_bank, addr_lo};

  assign scr_x = {1'b0, attr.x} + 10'(objx);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
      objx   <= '0;
      pix    <= '0;
    end else begin
      if (walk_start) begin
        active <= 1'b1;
        objx   <= '0;
      end else if (active) begin
        if (last_pix) begin
          active <= 1'b0;
        end else begin
          objx <= objx + 1'b1;
        end
      end
      pix.valid    <= active;
      pix.last     <= active && last_pix;
      // past the right edge, saturate so it never wraps onto the line
      pix.x        <= scr_x[9] ? '1 : scr_x[8:0];
      pix.pal_mode <= attr.pal_mode;
      pix.pal_bank <= attr.pal_bank;
      pix.pal_no   <= attr.pal_no;
      pix.idx      <= '0;
    end
  end

endmodule

/* hdl/vpu_sp_palette_lookup.sv */
`timescale 1ns/100ps
`include "vpu_sp_cfg.svh"

module vpu_sp_palette_lookup (
  input  logic                  clk,
  input  logic                  rst_n,
  input  vpu_sp_pkg::sp_pix_t   pix_in,
  input  logic [7:0]            tile_rdata,
  output vpu_mem_pkg::pal_req_t pal_req,
  output logic                  lb_rd_en,
  output logic [`LB_ADDR_W-1:0] lb_rd_addr,
  output vpu_sp_pkg::sp_pix_t   pix_out
);

  logic on_screen;

  assign on_screen = pix_in.valid && (pix_in.x < 9'(`SCREEN_W));

  // mode 1 picks one of 16 sub-palettes by pal_no
  assign pal_req.en   = on_screen;
  assign pal_req.addr = pix_in.pal_mode ? {pix_in.pal_bank, pix_in.pal_no, tile_rdata[3:0]}
                                        : {pix_in.pal_bank, tile_rdata};

  // destination read for the same x, returns with the color
  assign lb_rd_en   = on_screen;
  assign lb_rd_addr = pix_in.x[`LB_ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_out <= '0;
    end else begin
      pix_out       <= pix_in;
      pix_out.valid <= on_screen;
      pix_out.idx   <= tile_rdata;
    end
  end

endmodule

/* hdl/vpu_sp_color_merge.sv */
`timescale 1ns/100ps
`include "vpu_sp_cfg.svh"

module vpu_sp_color_merge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  vpu_sp_pkg::sp_pix_t   pix,
  input  logic [31:0]           pal_rdata,
  input  vpu_sp_pkg::sp_argb_t  lb_rdata,
  output logic                  lb_wr_en,
  output logic [`LB_ADDR_W-1:0] lb_wr_addr,
  output vpu_sp_pkg::sp_argb_t  lb_wr_data,
  output logic                  pass_done
);
  import vpu_sp_pkg::*;

  sp_argb_t src;

  // one channel, weighted by source alpha
  function automatic logic [7:0] mix(input logic [7:0] d, input logic [7:0] s,
                                     input logic [7:0] a);
    logic [15:0] sum;
    sum = 16'(d) * 16'(8'd255 - a) + 16'(s) * 16'(a);
    return sum[15:8];
  endfunction

  function automatic sp_argb_t blend(input sp_argb_t dst, input sp_argb_t s);
    sp_argb_t   res;
    logic [8:0] a_sum;
    a_sum = {1'b0, dst.a} + {1'b0, s.a};
    if (s.a == 8'd0) begin
      res = dst;
    end else if (s.a == 8'd255) begin
      res = s;
    end else begin
      res.a = a_sum[8:1];
      res.r = mix(dst.r, s.r, s.a);
      res.g = mix(dst.g, s.g, s.a);
      res.b = mix(dst.b, s.b, s.a);
    end
    return res;
  endfunction

  assign src = sp_argb_t'(pal_rdata);

  assign lb_wr_en   = pix.valid;
  assign lb_wr_addr = pix.x[`LB_ADDR_W-1:0];
  assign lb_wr_data = blend(lb_rdata, src);

  // last pixel written this cycle, sprite pass complete
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pass_done <= 1'b0;
    end else begin
      pass_done <= pix.last;
    end
  end

endmodule

/* hdl/vpu_sp.sv */
`timescale 1ns/100ps
`include "vpu_sp_cfg.svh"

module vpu_sp (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   line_start,
  input  logic [7:0]             line_y,
  output logic                   busy,
  output logic                   line_done,
  output vpu_mem_pkg::param_req_t param_req,
  input  logic [31:0]            param_rdata,
  output vpu_mem_pkg::tile_req_t tile_req,
  input  logic [7:0]             tile_rdata,
  output vpu_mem_pkg::pal_req_t  pal_req,
  input  logic [31:0]            pal_rdata,
  output vpu_mem_pkg::lb_req_t   lb_req,
  input  vpu_sp_pkg::sp_argb_t   lb_rdata
);
  import vpu_sp_pkg::*;

  logic                  load_start;
  logic                  load_done;
  logic                  visible;
  logic                  walk_start;
  logic                  pass_done;
  logic [`SP_IDX_W-1:0]  sp_idx;
  logic [7:0]            cur_y;
  sp_attr_t              attr;
  sp_pix_t               pix_fetch;
  sp_pix_t               pix_pal;
  logic                  lb_rd_en;
  logic [`LB_ADDR_W-1:0] lb_rd_addr;
  logic                  lb_wr_en;
  logic [`LB_ADDR_W-1:0] lb_wr_addr;
  sp_argb_t              lb_wr_data;

  vpu_sp_sequencer u_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .line_start (line_start),
    .line_y     (line_y),
    .busy       (busy),
    .line_done  (line_done),
    .load_start (load_start),
    .sp_idx     (sp_idx),
    .load_done  (load_done),
    .visible    (visible),
    .walk_start (walk_start),
    .pass_done  (pass_done),
    .cur_y      (cur_y)
  );

  vpu_sp_param_load u_param_load (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_start  (load_start),
    .sp_idx      (sp_idx),
    .cur_y       (cur_y),
    .param_req   (param_req),
    .param_rdata (param_rdata),
    .load_done   (load_done),
    .visible     (visible),
    .attr        (attr)
  );

  vpu_sp_tile_fetch u_tile_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .walk_start (walk_start),
    .attr       (attr),
    .cur_y      (cur_y),
    .tile_req   (tile_req),
    .pix        (pix_fetch)
  );

  vpu_sp_palette_lookup u_palette_lookup (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_in     (pix_fetch),
    .tile_rdata (tile_rdata),
    .pal_req    (pal_req),
    .lb_rd_en   (lb_rd_en),
    .lb_rd_addr (lb_rd_addr),
    .pix_out    (pix_pal)
  );

  vpu_sp_color_merge u_color_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix        (pix_pal),
    .pal_rdata  (pal_rdata),
    .lb_rdata   (lb_rdata),
    .lb_wr_en   (lb_wr_en),
    .lb_wr_addr (lb_wr_addr),
    .lb_wr_data (lb_wr_data),
    .pass_done  (pass_done)
  );

  assign lb_req.rd_en   = lb_rd_en;
  assign lb_req.rd_addr = lb_rd_addr;
  assign lb_req.wr_en   = lb_wr_en;
  assign lb_req.wr_addr = lb_wr_addr;
  assign lb_req.wdata   = lb_wr_data;

endmodule

/* dv/vpu_sp_assertions.sv */
`timescale 1ns/100ps

module vpu_sp_assertions (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    line_start,
  input logic                    busy,
  input logic                    line_done,
  input vpu_mem_pkg::param_req_t param_req,
  input vpu_mem_pkg::tile_req_t  tile_req,
  input vpu_mem_pkg::pal_req_t   pal_req,
  input vpu_mem_pkg::lb_req_t    lb_req
);

  int assert_errs = 0;

  // first cycle out of reset
  reset_clean: assert property (@(posedge clk) $rose(rst_n) |-> !busy && !line_done)
    else begin
      $error("busy or line_done high right after reset");
      assert_errs++;
    end

  // no memory traffic outside a line
  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> !(param_req.en || tile_req.en || pal_req.en || lb_req.rd_en || lb_req.wr_en))
    else begin
      $error("memory port enabled while idle");
      assert_errs++;
    end

  write_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    lb_req.wr_en |-> busy)
    else begin
      $error("line buffer write outside busy");
      assert_errs++;
    end

  start_accepted: assert property (@(posedge clk) disable iff (!rst_n)
    line_start && !busy |=> busy)
    else begin
      $error("busy did not rise after line_start");
      assert_errs++;
    end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    line_done |-> !busy ##1 !line_done)
    else begin
      $error("line_done not a single cycle with busy low");
      assert_errs++;
    end

  busy_ends_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> line_done)
    else begin
      $error("busy fell without line_done");
      assert_errs++;
    end

endmodule

/* dv/vpu_sp_checker.sv */
`timescale 1ns/100ps
`include "vpu_sp_cfg.svh"

module vpu_sp_checker (
  input logic       clk,
  input logic       rst_n,
  input logic       line_start,
  input logic [7:0] line_y,
  input logic       busy,
  input logic       line_done
);
  import vpu_sp_pkg::*;

  sp_argb_t expected [`SCREEN_W];
  int       pixel_errs    = 0;
  int       proto_errs    = 0;
  int       lines_checked = 0;
  int       open_lines    = 0;
  logic     start_seen    = 1'b0;

  function automatic sp_argb_t blend_pixel(input sp_argb_t dst, input sp_argb_t src);
    sp_argb_t res;
    int       keep;
    keep = 255 - int'(src.a);
    res  = dst;
    if (src.a == 8'd255) begin
      res = src;
    end else if (src.a != 8'd0) begin
      res.a = 8'((int'(dst.a) + int'(src.a)) / 2);
      res.r = 8'((int'(dst.r) * keep + int'(src.r) * int'(src.a)) / 256);
      res.g = 8'((int'(dst.g) * keep + int'(src.g) * int'(src.a)) / 256);
      res.b = 8'((int'(dst.b) * keep + int'(src.b) * int'(src.a)) / 256);
    end
    return res;
  endfunction

  // replay the sprite table in index order over a copy of the line
  task automatic build_expected(input int y_line);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [7:0]  pidx;
    int          i;
    int          size;
    int          sy;
    int          sx;
    int          ox;
    int          objy;
    int          tnum;
    int          taddr;
    int          paddr;
    for (i = 0; i < `SCREEN_W; i++) begin
      expected[i] = tb_vpu_sp.lb_mem[i];
    end
    for (i = 0; i < `SP_COUNT; i++) begin
      w0   = tb_vpu_sp.param_mem[i * `PARAM_WORDS];
      w1   = tb_vpu_sp.param_mem[i * `PARAM_WORDS + 1];
      size = `HW_TILE_W << w0[25:24];
      sy   = w0[7:0];
      if (w0[31] && sy <= y_line && y_line < sy + size) begin
        objy = y_line - sy;
        for (ox = 0; ox < size; ox++) begin
          sx = int'(w0[16:8]) + ox;
          if (sx < `SCREEN_W) begin
            tnum  = (int'(w1[23:16]) + ox / `HW_TILE_W
                  + (objy / `HW_TILE_W) * (size / `HW_TILE_W)) % 256;
            taddr = int'(w1[29:28]) * (1 << (`TILE_ADDR_W - `TILE_BANK_W))
                  + tnum * `HW_TILE_W * `HW_TILE_W
                  + (objy % `HW_TILE_W) * `HW_TILE_W + ox % `HW_TILE_W;
            pidx  = tb_vpu_sp.tile_mem[taddr];
            if (w1[6]) begin
              paddr = int'(w1[5:4]) * 256 + int'(w1[3:0]) * 16 + int'(pidx[3:0]);
            end else begin
              paddr = int'(w1[5:4]) * 256 + int'(pidx);
            end
            expected[sx] = blend_pixel(expected[sx], tb_vpu_sp.pal_mem[paddr]);
          end
        end
      end
    end
  endtask

  task automatic compare_line();
    int x;
    for (x = 0; x < `SCREEN_W; x++) begin
      if (tb_vpu_sp.lb_mem[x] !== expected[x]) begin
        $display("ERR line_render line %0d x %0d expected %08h actual %08h",
                 lines_checked, x, expected[x], tb_vpu_sp.lb_mem[x]);
        pixel_errs++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      start_seen <= 1'b0;
    end else begin
      if (start_seen && !busy) begin
        $display("busy did not rise in the cycle after an accepted line_start");
        proto_errs++;
      end
      if (line_done) begin
        if (open_lines != 1) begin
          $display("line_done came with %0d lines open instead of one", open_lines);
          proto_errs++;
        end
        compare_line();
        lines_checked++;
        open_lines = 0;
      end
      start_seen <= line_start && !busy;
      // snapshot of the memories at the accepted start
      if (line_start && !busy) begin
        build_expected(int'(line_y));
        open_lines++;
      end
    end
  end

endmodule

/* dv/tb_vpu_sp.sv */
`timescale 1ns/100ps
`include "vpu_sp_cfg.svh"

module tb_vpu_sp;
  import vpu_sp_pkg::*;
  import vpu_mem_pkg::*;

  localparam int NUM_LINES  = 40;
  localparam int CLK_PERIOD = 20;
  // 64 pixel walk plus load and drain per sprite
  localparam int LINE_LIMIT      = `SP_COUNT * 75;
  localparam int WATCHDOG_CYCLES = NUM_LINES * (LINE_LIMIT + 20) + 100;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        line_start;
  logic [7:0]  line_y;
  logic        busy;
  logic        line_done;
  param_req_t  param_req;
  logic [31:0] param_rdata;
  tile_req_t   tile_req;
  logic [7:0]  tile_rdata;
  pal_req_t    pal_req;
  logic [31:0] pal_rdata;
  lb_req_t     lb_req;
  sp_argb_t    lb_rdata;

  logic [31:0] param_mem [1 << `PARAM_ADDR_W];
  logic [7:0]  tile_mem  [1 << `TILE_ADDR_W];
  logic [31:0] pal_mem   [1 << `PAL_ADDR_W];
  sp_argb_t    lb_mem    [1 << `LB_ADDR_W];
  logic [31:0] rng;
  int          tb_errs;

  always #(CLK_PERIOD / 2) clk = ~clk;

  vpu_sp u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .line_start  (line_start),
    .line_y      (line_y),
    .busy        (busy),
    .line_done   (line_done),
    .param_req   (param_req),
    .param_rdata (param_rdata),
    .tile_req    (tile_req),
    .tile_rdata  (tile_rdata),
    .pal_req     (pal_req),
    .pal_rdata   (pal_rdata),
    .lb_req      (lb_req),
    .lb_rdata    (lb_rdata)
  );

  vpu_sp_checker u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .line_start (line_start),
    .line_y     (line_y),
    .busy       (busy),
    .line_done  (line_done)
  );

  bind vpu_sp vpu_sp_assertions u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .line_start (line_start),
    .busy       (busy),
    .line_done  (line_done),
    .param_req  (param_req),
    .tile_req   (tile_req),
    .pal_req    (pal_req),
    .lb_req     (lb_req)
  );

  // all four memories answer one cycle after the request
  always @(posedge clk) begin
    if (param_req.en) begin
      param_rdata <= param_mem[param_req.addr];
    end
    if (tile_req.en) begin
      tile_rdata <= tile_mem[tile_req.addr];
    end
    if (pal_req.en) begin
      pal_rdata <= pal_mem[pal_req.addr];
    end
    if (lb_req.rd_en) begin
      lb_rdata <= lb_mem[lb_req.rd_addr];
    end
    if (lb_req.wr_en) begin
      lb_mem[lb_req.wr_addr] <= lb_req.wdata;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic fill_memories(input logic [7:0] y_line);
    logic [31:0] r;
    logic [31:0] w0;
    logic [7:0]  span;
    int          i;
    for (i = 0; i < `SP_COUNT; i++) begin
      r         = next_rand();
      w0        = next_rand();
      w0[31]    = (r[2:0] != 3'd0);
      w0[25:24] = r[4:3];
      // some sprites hang over the right edge
      w0[16:8]  = r[5] ? {1'b0, r[13:6]} : 9'd192 + {1'b0, r[13:6]};
      span      = 8'(`HW_TILE_W << r[4:3]);
      // mostly placed so the sprite rows reach the line
      w0[7:0]   = (r[16:14] != 3'd0) ? y_line - (r[24:17] % (span + 8'd4)) : r[24:17];
      param_mem[i * `PARAM_WORDS]     <= w0;
      param_mem[i * `PARAM_WORDS + 1] <= next_rand();
    end
    for (i = 0; i < (1 << `TILE_ADDR_W); i += 4) begin
      r               = next_rand();
      tile_mem[i]     <= r[7:0];
      tile_mem[i + 1] <= r[15:8];
      tile_mem[i + 2] <= r[23:16];
      tile_mem[i + 3] <= r[31:24];
    end
    // a quarter transparent, a quarter opaque
    for (i = 0; i < (1 << `PAL_ADDR_W); i++) begin
      r = next_rand();
      if (r[25:24] == 2'd0) begin
        r[31:24] = 8'd0;
      end else if (r[25:24] == 2'd1) begin
        r[31:24] = 8'd255;
      end
      pal_mem[i] <= r;
    end
    for (i = 0; i < (1 << `LB_ADDR_W); i++) begin
      lb_mem[i] <= next_rand();
    end
  endtask

  initial begin
    logic [31:0] r;
    int          line_no;
    int          cycles;
    rng         = 32'h4c28;
    tb_errs     = 0;
    rst_n       <= 1'b0;
    line_start  <= 1'b0;
    line_y      <= 8'd0;
    param_rdata <= '0;
    tile_rdata  <= '0;
    pal_rdata   <= '0;
    lb_rdata    <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (line_no = 0; line_no < NUM_LINES; line_no++) begin
      r = next_rand();
      fill_memories(r[7:0]);
      @(posedge clk);
      line_y     <= r[7:0];
      line_start <= 1'b1;
      @(posedge clk);
      line_start <= 1'b0;
      repeat (2) @(posedge clk);
      // start again mid-line with another y, must be ignored
      line_start <= 1'b1;
      line_y     <= r[15:8];
      @(posedge clk);
      line_start <= 1'b0;
      cycles = 0;
      do begin
        @(posedge clk);
        cycles++;
      end while (!line_done && cycles < LINE_LIMIT);
      if (!line_done) begin
        $display("line %0d did not finish within %0d cycles", line_no, LINE_LIMIT);
        $display("Testbench failed");
        $finish;
      end
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (u_chk.lines_checked != NUM_LINES) begin
      $display("only %0d of %0d lines ended with line_done", u_chk.lines_checked, NUM_LINES);
      tb_errs++;
    end
    $display("lines %0d, pixel errors %0d, protocol errors %0d, assertion errors %0d, other %0d",
             u_chk.lines_checked, u_chk.pixel_errs, u_chk.proto_errs,
             u_dut.u_assert.assert_errs, tb_errs);
    if (u_chk.pixel_errs + u_chk.proto_errs + u_dut.u_assert.assert_errs + tb_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before all lines were done", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* all.f */
+incdir+hdl
hdl/vpu_sp_pkg.sv
hdl/vpu_mem_pkg.sv
hdl/vpu_sp_sequencer.sv
hdl/vpu_sp_param_load.sv
hdl/vpu_sp_tile_fetch.sv
hdl/vpu_sp_palette_lookup.sv
hdl/vpu_sp_color_merge.sv
hdl/vpu_sp.sv
dv/vpu_sp_assertions.sv
dv/vpu_sp_checker.sv
dv/tb_vpu_sp.sv
